// File: risc_core.f
verilog/risc_pkg.sv
verilog/register_file.sv
verilog/adder_unit.sv
verilog/logic_unit.sv
verilog/result_stage.sv
verilog/decode_stage.sv
verilog/risc_core.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/risc_core_sva.sv
testbench/tb_risc_core.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the risc_core testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module tb_risc_core \
	-f risc_core.f \
	-o sim_risc_core
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_output=$(./obj_dir/sim_risc_core)
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx 'PASS: all tests'; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: testbench/risc_core_sva.sv
`timescale 1ns/1ps

module risc_core_sva
(
	input logic clk,
	input logic reset,
	input logic instr_valid,
	input logic wb_valid,
	input logic c_flag,
	input logic z_flag
);

	// Count of failed assertions
	int fail_count = 0;

	// Writeback register held clear in reset
	reset_clears_wb: assert property (@(posedge clk) reset && $past(reset) |-> !wb_valid)
		else
		begin
			$error("wb_valid high during reset");
			fail_count++;
		end

	// Sampled at k, presented after k+2, seen here at k+3
	bubble_gives_no_wb: assert property (@(posedge clk) disable iff (reset)
		!$past(instr_valid, 3) |-> !wb_valid)
		else
		begin
			$error("wb_valid high for a bubble");
			fail_count++;
		end

	// Flags register together with a writeback only
	flags_follow_wb: assert property (@(posedge clk) disable iff (reset)
		!($stable(c_flag) && $stable(z_flag)) |-> wb_valid)
		else
		begin
			$error("Flag changed without a writeback");
			fail_count++;
		end

endmodule

bind risc_core risc_core_sva u_risc_core_sva
(
	.clk         (clk),
	.reset       (reset),
	.instr_valid (instr_valid),
	.wb_valid    (wb_valid),
	.c_flag      (c_flag),
	.z_flag      (z_flag)
);

// File: testbench/tb_checker.sv
`timescale 1ns/1ps

module tb_checker
(
	input  logic                clk,
	input  logic                reset,
	input  risc_pkg::word_t     instr,
	input  logic                instr_valid,
	input  logic                exp_write,
	input  risc_pkg::reg_addr_t exp_dest,
	input  risc_pkg::word_t     exp_data,
	input  logic                wb_valid,
	input  risc_pkg::reg_addr_t wb_dest,
	input  risc_pkg::word_t     wb_data,
	input  logic                c_flag,
	input  logic                z_flag,
	output int                  mismatch_count,
	output int                  other_count,
	output int                  pending
);
	import risc_pkg::*;

	// Architectural state of the reference model
	word_t model_regs [8];
	logic  model_c;
	logic  model_z;
	int    cycle;

	// Predictions in program order
	// Packed as write, dest, data, C, Z
	int          due_q [$];
	logic [21:0] pred_q [$];

	task automatic report_mismatch(input string name, input word_t got, input word_t exp);
		mismatch_count++;
		$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
	endtask

	// One instruction, straight from the ISA rules
	task automatic model_step(input word_t ins);
		logic [3:0]  op;
		reg_addr_t   ra;
		reg_addr_t   rb;
		reg_addr_t   rc;
		word_t       a;
		word_t       b;
		logic [16:0] s;
		logic        run;
		logic        wr;
		reg_addr_t   dst;
		word_t       res;
		op  = ins[15:12];
		ra  = ins[11:9];
		rb  = ins[8:6];
		rc  = ins[5:3];
		a   = model_regs[ra];
		b   = model_regs[rb];
		s   = '0;
		wr  = 1'b0;
		dst = '0;
		res = '0;
		// Failed carry or zero condition skips ADD and NDU
		run = !((ins[1:0] == COND_CARRY && !model_c) || (ins[1:0] == COND_ZERO && !model_z));
		case (op)
			ADI:
			begin
				s   = {1'b0, a} + {1'b0, {{10{ins[5]}}, ins[5:0]}};
				wr  = 1'b1;
				dst = rb;
			end
			ADD:
			begin
				s   = {1'b0, a} + {1'b0, b};
				wr  = run;
				dst = rc;
			end
			NDU:
			begin
				res = ~(a & b);
				wr  = run;
				dst = rc;
			end
			LHI:
			begin
				res = {ins[8:0], 7'b0};
				wr  = 1'b1;
				dst = ra;
			end
			default:
				wr = 1'b0;
		endcase
		if (op == ADD || op == ADI)
			res = s[15:0];
		// Adds set both flags, NDU only Z, LHI none
		if (wr && (op == ADD || op == ADI))
			model_c = s[16];
		if (wr && op != LHI)
			model_z = (res == 16'h0000);
		if (wr)
			model_regs[dst] = res;
		// Hand-written table row must agree with the model
		if (wr !== exp_write || (wr && (dst !== exp_dest || res !== exp_data)))
		begin
			other_count++;
			$display("Table row for instruction 0x%0h disagrees with the reference model", ins);
		end
		due_q.push_back(cycle + 3);
		pred_q.push_back({wr, dst, res, model_c, model_z});
	endtask

	task automatic compare_writeback(input logic [21:0] pred);
		if (pred[21] && !wb_valid)
		begin
			other_count++;
			$display("Expected writeback to R%0d is missing", pred[20:18]);
		end
		else if (!pred[21] && wb_valid)
		begin
			other_count++;
			$display("Writeback to R%0d where the instruction writes nothing", wb_dest);
		end
		else if (pred[21])
		begin
			if (wb_dest !== pred[20:18])
				report_mismatch("wb_dest", 16'(wb_dest), 16'(pred[20:18]));
			if (wb_data !== pred[17:2])
				report_mismatch("wb_data", wb_data, pred[17:2]);
		end
		// Flags checked for skipped instructions too
		if (c_flag !== pred[1])
			report_mismatch("c_flag", 16'(c_flag), 16'(pred[1]));
		if (z_flag !== pred[0])
			report_mismatch("z_flag", 16'(z_flag), 16'(pred[0]));
	endtask

	// Outputs are registered, so posedge sampling sees the settled values
	always @(posedge clk)
	begin : check_edge
		logic [21:0] pred;
		if (reset)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				model_regs[i] = '0;
			model_c        = 1'b0;
			model_z        = 1'b0;
			cycle          = 0;
			mismatch_count = 0;
			other_count    = 0;
			due_q.delete();
			pred_q.delete();
		end
		else
		begin
			cycle++;
			// Sampled at edge k, visible here at edge k+3
			if (due_q.size() > 0 && due_q[0] == cycle)
			begin
				void'(due_q.pop_front());
				pred = pred_q.pop_front();
				compare_writeback(pred);
			end
			else if (wb_valid)
			begin
				other_count++;
				$display("Writeback to R%0d with no instruction due", wb_dest);
			end
			if (instr_valid)
				model_step(instr);
		end
		pending = due_q.size();
	end

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
(
	output logic clk,
	output logic reset
);

	// 8 ns period
	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Reset held for the first 8 rising edges
	initial
	begin
		reset = 1'b1;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

// File: testbench/tb_risc_core.sv
`timescale 1ns/1ps

module tb_risc_core;
	import risc_pkg::*;

	logic      clk;
	logic      reset;
	word_t     instr;
	logic      instr_valid;
	logic      wb_valid;
	reg_addr_t wb_dest;
	word_t     wb_data;
	logic      c_flag;
	logic      z_flag;

	// Row expectations travel to the checker with the instruction
	logic      exp_write;
	reg_addr_t exp_dest;
	word_t     exp_data;
	int        mismatch_count;
	int        other_count;
	int        pending;

	// Stimulus table columns
	word_t     tbl_instr [$];
	logic      tbl_write [$];
	reg_addr_t tbl_dest [$];
	word_t     tbl_data [$];

	logic [7:0] lfsr;
	int         watchdog_cycles;

	tb_clock_gen u_clock_gen
	(
		.clk   (clk),
		.reset (reset)
	);

	risc_core u_dut
	(
		.clk         (clk),
		.reset       (reset),
		.instr       (instr),
		.instr_valid (instr_valid),
		.wb_valid    (wb_valid),
		.wb_dest     (wb_dest),
		.wb_data     (wb_data),
		.c_flag      (c_flag),
		.z_flag      (z_flag)
	);

	tb_checker u_checker
	(
		.clk            (clk),
		.reset          (reset),
		.instr          (instr),
		.instr_valid    (instr_valid),
		.exp_write      (exp_write),
		.exp_dest       (exp_dest),
		.exp_data       (exp_data),
		.wb_valid       (wb_valid),
		.wb_dest        (wb_dest),
		.wb_data        (wb_data),
		.c_flag         (c_flag),
		.z_flag         (z_flag),
		.mismatch_count (mismatch_count),
		.other_count    (other_count),
		.pending        (pending)
	);

	// Fibonacci LFSR, taps 8 6 5 4
	function automatic logic [7:0] lfsr_step(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	function automatic word_t encode_rrr(input opcode_t op, input reg_addr_t ra,
		input reg_addr_t rb, input reg_addr_t rc, input cond_t cond);
		return {op, ra, rb, rc, 1'b0, cond};
	endfunction

	function automatic word_t encode_adi(input reg_addr_t ra, input reg_addr_t rb,
		input logic [5:0] imm);
		return {ADI, ra, rb, imm};
	endfunction

	function automatic word_t encode_lhi(input reg_addr_t ra, input logic [8:0] imm);
		return {LHI, ra, imm};
	endfunction

	task automatic add_row(input word_t ins, input logic wr, input reg_addr_t dst,
		input word_t data);
		tbl_instr.push_back(ins);
		tbl_write.push_back(wr);
		tbl_dest.push_back(dst);
		tbl_data.push_back(data);
	endtask

	initial
	begin
		logic [1:0] gap;
		instr       = '0;
		instr_valid = 1'b0;
		exp_write   = 1'b0;
		exp_dest    = '0;
		exp_data    = '0;
		lfsr        = 8'd85;

		// Loads, every register written before it is read
		add_row(encode_lhi(3'd1, 9'h1FF), 1'b1, 3'd1, 16'hFF80);
		add_row(encode_lhi(3'd2, 9'h001), 1'b1, 3'd2, 16'h0080);
		add_row(encode_adi(3'd2, 3'd3, 6'h3F), 1'b1, 3'd3, 16'h007F);
		add_row(encode_adi(3'd3, 3'd4, 6'h05), 1'b1, 3'd4, 16'h0084);
		// Dependent chain, forwarding at distances 1 to 3
		add_row(encode_rrr(ADD, 3'd1, 3'd4, 3'd5, COND_NONE), 1'b1, 3'd5, 16'h0004);
		add_row(encode_rrr(NDU, 3'd5, 3'd4, 3'd6, COND_NONE), 1'b1, 3'd6, 16'hFFFB);
		add_row(encode_rrr(ADD, 3'd4, 3'd6, 3'd7, COND_NONE), 1'b1, 3'd7, 16'h007F);
		add_row(encode_rrr(ADD, 3'd5, 3'd7, 3'd5, COND_NONE), 1'b1, 3'd5, 16'h0083);
		add_row(encode_rrr(NDU, 3'd6, 3'd7, 3'd0, COND_NONE), 1'b1, 3'd0, 16'hFF84);
		// Carry out with zero sum, then NDU and LHI flag effects
		add_row(encode_rrr(ADD, 3'd1, 3'd2, 3'd6, COND_NONE), 1'b1, 3'd6, 16'h0000);
		add_row(encode_rrr(NDU, 3'd1, 3'd1, 3'd7, COND_NONE), 1'b1, 3'd7, 16'h007F);
		add_row(encode_lhi(3'd3, 9'h000), 1'b1, 3'd3, 16'h0000);
		add_row(encode_rrr(NDU, 3'd6, 3'd6, 3'd4, COND_NONE), 1'b1, 3'd4, 16'hFFFF);
		add_row(encode_rrr(NDU, 3'd4, 3'd4, 3'd5, COND_NONE), 1'b1, 3'd5, 16'h0000);
		// Conditional forms, taken and skipped
		add_row(encode_rrr(ADD, 3'd2, 3'd7, 3'd0, COND_ZERO), 1'b1, 3'd0, 16'h00FF);
		// Skipped rows that would change the flags if they ran
		add_row(encode_rrr(ADD, 3'd1, 3'd2, 3'd1, COND_CARRY), 1'b0, 3'd0, 16'h0000);
		add_row(encode_rrr(NDU, 3'd4, 3'd4, 3'd1, COND_CARRY), 1'b0, 3'd0, 16'h0000);
		add_row(encode_rrr(ADD, 3'd1, 3'd2, 3'd3, COND_NONE), 1'b1, 3'd3, 16'h0000);
		add_row(encode_rrr(NDU, 3'd1, 3'd0, 3'd2, COND_ZERO), 1'b1, 3'd2, 16'hFF7F);
		add_row(encode_rrr(ADD, 3'd1, 3'd2, 3'd4, COND_ZERO), 1'b0, 3'd0, 16'h0000);
		add_row(encode_rrr(ADD, 3'd2, 3'd2, 3'd4, COND_CARRY), 1'b1, 3'd4, 16'hFEFE);
		add_row(encode_rrr(NDU, 3'd4, 3'd4, 3'd5, COND_ZERO), 1'b0, 3'd0, 16'h0000);
		add_row(encode_rrr(NDU, 3'd4, 3'd4, 3'd5, COND_CARRY), 1'b1, 3'd5, 16'h0101);
		// Unknown opcode writes nothing
		add_row(16'h7000, 1'b0, 3'd0, 16'h0000);
		add_row(encode_rrr(ADD, 3'd5, 3'd4, 3'd6, COND_NONE), 1'b1, 3'd6, 16'hFFFF);

		// Two passes, bubble gaps of up to 3 cycles
		watchdog_cycles = 2 * tbl_instr.size() * 6 + 100;

		@(negedge reset);
		// First pass back to back, second with random bubbles
		for (int pass = 0; pass < 2; pass++)
		begin
			for (int row = 0; row < tbl_instr.size(); row++)
			begin
				if (pass == 1)
				begin
					lfsr = lfsr_step(lfsr);
					gap[0] = lfsr[0];
					lfsr = lfsr_step(lfsr);
					gap[1] = lfsr[0];
					repeat (gap)
					begin
						@(posedge clk);
						instr_valid <= 1'b0;
					end
				end
				@(posedge clk);
				instr       <= tbl_instr[row];
				instr_valid <= 1'b1;
				exp_write   <= tbl_write[row];
				exp_dest    <= tbl_dest[row];
				exp_data    <= tbl_data[row];
			end
		end
		@(posedge clk);
		instr_valid <= 1'b0;

		// Drain, then a few idle cycles for stray writebacks
		do
		begin
			@(negedge clk);
		end
		while (pending != 0);
		repeat (4) @(negedge clk);

		$display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
			mismatch_count, other_count, u_dut.u_risc_core_sva.fail_count);
		if (mismatch_count == 0 && other_count == 0
			&& u_dut.u_risc_core_sva.fail_count == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// Watchdog
	initial
	begin
		#1;
		repeat (watchdog_cycles) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: verilog/adder_unit.sv
`timescale 1ns/1ps

module adder_unit
(
	input  risc_pkg::word_t op_a,
	input  risc_pkg::word_t op_b,
	output risc_pkg::word_t sum,
	output logic            carry
);
	import risc_pkg::*;

	// One extra bit to catch the carry out
	logic [WORD_WIDTH:0] full_sum;

	// Shared by ADD and ADI
	// ADI arrives with the immediate already in op_b
	assign full_sum = {1'b0, op_a} + {1'b0, op_b};

	// Low bits are the result, top bit feeds C
	assign sum   = full_sum[WORD_WIDTH-1:0];
	assign carry = full_sum[WORD_WIDTH];

endmodule

// File: verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
(
	input  logic                clk,
	input  logic                reset,
	input  risc_pkg::word_t     instr,
	input  logic                instr_valid,
	input  risc_pkg::word_t     ex_result,
	input  logic                ex_write,
	input  risc_pkg::reg_addr_t ex_dest,
	input  logic                wb_valid,
	input  risc_pkg::reg_addr_t wb_dest,
	input  risc_pkg::word_t     wb_data,
	output risc_pkg::word_t     op_a,
	output risc_pkg::word_t     op_b,
	output risc_pkg::opcode_t   ex_opcode,
	output risc_pkg::cond_t     ex_cond,
	output logic                ex_valid,
	output risc_pkg::reg_addr_t ex_dest_out
);
	import risc_pkg::*;

	word_t     dec_instr;
	logic      dec_valid;
	opcode_t   dec_opcode;
	cond_t     dec_cond;
	reg_addr_t dec_ra;
	reg_addr_t dec_rb;
	reg_addr_t dec_rc;
	reg_addr_t dec_dest;
	word_t     rf_data_a;
	word_t     rf_data_b;
	word_t     fwd_a;
	word_t     fwd_b;
	word_t     imm6_ext;
	word_t     imm9_ext;
	word_t     operand_b;

	// Youngest producer wins, execute before writeback
	function automatic word_t forward_sel(input reg_addr_t src, input word_t rf_value);
		word_t value;
		if (ex_write && ex_dest == src)
			value = ex_result;
		else if (wb_valid && wb_dest == src)
			value = wb_data;
		else
			value = rf_value;
		return value;
	endfunction

	// Decode register, a cycle without the strobe is a bubble
	always_ff @(posedge clk)
	begin
		if (reset)
			dec_valid <= 1'b0;
		else
			dec_valid <= instr_valid;
	end

	always_ff @(posedge clk)
	begin
		if (instr_valid)
			dec_instr <= instr;
	end

	// Field split
	assign dec_opcode = opcode_t'(dec_instr[OPCODE_LSB +: OPCODE_WIDTH]);
	assign dec_ra     = dec_instr[RA_LSB +: REG_ADDR_WIDTH];
	assign dec_rb     = dec_instr[RB_LSB +: REG_ADDR_WIDTH];
	assign dec_rc     = dec_instr[RC_LSB +: REG_ADDR_WIDTH];
	assign dec_cond   = dec_instr[COND_LSB +: COND_WIDTH];

	// ADI imm6 is signed, LHI imm9 goes in unsigned
	assign imm6_ext = {{(WORD_WIDTH-IMM6_WIDTH){dec_instr[IMM6_WIDTH-1]}},
		dec_instr[IMM6_WIDTH-1:0]};
	assign imm9_ext = {{(WORD_WIDTH-IMM9_WIDTH){1'b0}}, dec_instr[IMM9_WIDTH-1:0]};

	// Write port is driven straight from the writeback register
	register_file u_register_file
	(
		.clk         (clk),
		.reset       (reset),
		.read_addr_a (dec_ra),
		.read_addr_b (dec_rb),
		.read_data_a (rf_data_a),
		.read_data_b (rf_data_b),
		.write_en    (wb_valid),
		.write_addr  (wb_dest),
		.write_data  (wb_data)
	);

	// Forward mux also follows the execute and writeback ports
	always_comb
	begin
		fwd_a = forward_sel(dec_ra, rf_data_a);
		fwd_b = forward_sel(dec_rb, rf_data_b);
	end

	// Destination field and second operand per opcode
	always_comb
	begin
		case (dec_opcode)
			ADI:
			begin
				dec_dest  = dec_rb;
				operand_b = imm6_ext;
			end
			LHI:
			begin
				dec_dest  = dec_ra;
				operand_b = imm9_ext;
			end
			default:
			begin
				dec_dest  = dec_rc;
				operand_b = fwd_b;
			end
		endcase
	end

	// Execute register
	always_ff @(posedge clk)
	begin
		if (reset)
			ex_valid <= 1'b0;
		else
			ex_valid <= dec_valid;
	end

	always_ff @(posedge clk)
	begin
		op_a        <= fwd_a;
		op_b        <= operand_b;
		ex_opcode   <= dec_opcode;
		ex_cond     <= dec_cond;
		ex_dest_out <= dec_dest;
	end

endmodule

// File: verilog/logic_unit.sv
`timescale 1ns/1ps

module logic_unit
(
	input  risc_pkg::opcode_t opcode,
	input  risc_pkg::word_t   op_a,
	input  risc_pkg::word_t   op_b,
	output risc_pkg::word_t   result
);
	import risc_pkg::*;

	always_comb
	begin
		case (opcode)
			// Bitwise NAND
			NDU: result = ~(op_a & op_b);
			// imm9 moved into bits 15..7, low bits zero
			LHI: result = word_t'(op_b << LHI_SHIFT);
			default: result = '0;
		endcase
	end

endmodule

// File: verilog/register_file.sv
`timescale 1ns/1ps

module register_file
(
	input  logic               clk,
	input  logic               reset,
	input  risc_pkg::reg_addr_t read_addr_a,
	input  risc_pkg::reg_addr_t read_addr_b,
	output risc_pkg::word_t    read_data_a,
	output risc_pkg::word_t    read_data_b,
	input  logic               write_en,
	input  risc_pkg::reg_addr_t write_addr,
	input  risc_pkg::word_t    write_data
);
	import risc_pkg::*;

	// Eight general purpose registers R0..R7
	word_t regs [NUM_REGS];

	// Single write port, cleared on reset
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_REGS; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (write_en)
		begin
			regs[write_addr] <= write_data;
		end
	end

	// Read ports
	// Write-through so a same-cycle write is seen by the reader
	always_comb
	begin
		if (write_en && write_addr == read_addr_a)
			read_data_a = write_data;
		else
			read_data_a = regs[read_addr_a];

		if (write_en && write_addr == read_addr_b)
			read_data_b = write_data;
		else
			read_data_b = regs[read_addr_b];
	end

endmodule

// File: verilog/result_stage.sv
`timescale 1ns/1ps

module result_stage
(
	input  logic                clk,
	input  logic                reset,
	input  logic                ex_valid,
	input  risc_pkg::opcode_t   ex_opcode,
	input  risc_pkg::cond_t     ex_cond,
	input  risc_pkg::reg_addr_t ex_dest,
	input  risc_pkg::word_t     sum,
	input  logic                carry,
	input  risc_pkg::word_t     logic_result,
	output risc_pkg::word_t     ex_result,
	output logic                ex_write,
	output logic                wb_valid,
	output risc_pkg::reg_addr_t wb_dest,
	output risc_pkg::word_t     wb_data,
	output logic                c_flag,
	output logic                z_flag
);
	import risc_pkg::*;

	logic is_arith;
	logic is_logic;
	logic is_cond_form;
	logic upd_c;
	logic upd_z;
	logic cond_ok;

	// Opcode classes and flag effects
	always_comb
	begin
		is_arith     = 1'b0;
		is_logic     = 1'b0;
		is_cond_form = 1'b0;
		upd_c        = 1'b0;
		upd_z        = 1'b0;
		case (ex_opcode)
			ADD:
			begin
				is_arith     = 1'b1;
				is_cond_form = 1'b1;
				upd_c        = 1'b1;
				upd_z        = 1'b1;
			end
			ADI:
			begin
				is_arith = 1'b1;
				upd_c    = 1'b1;
				upd_z    = 1'b1;
			end
			// NDU touches Z only
			NDU:
			begin
				is_logic     = 1'b1;
				is_cond_form = 1'b1;
				upd_z        = 1'b1;
			end
			// LHI leaves both flags
			LHI: is_logic = 1'b1;
			default: is_logic = 1'b0;
		endcase
	end

	// Condition against flags from the previous instruction
	always_comb
	begin
		cond_ok = 1'b1;
		if (is_cond_form)
		begin
			case (ex_cond)
				COND_NONE:  cond_ok = 1'b1;
				COND_CARRY: cond_ok = c_flag;
				COND_ZERO:  cond_ok = z_flag;
				default:    cond_ok = 1'b1;
			endcase
		end
	end

	// Also fed back to decode for distance-1 forwarding
	assign ex_result = is_arith ? sum : logic_result;
	assign ex_write  = ex_valid && (is_arith || is_logic) && cond_ok;

	// Writeback register and flags
	// A skipped or unknown instruction changes nothing
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wb_valid <= 1'b0;
			c_flag   <= 1'b0;
			z_flag   <= 1'b0;
		end
		else
		begin
			wb_valid <= ex_write;
			if (ex_write && upd_c)
				c_flag <= carry;
			if (ex_write && upd_z)
				z_flag <= (ex_result == '0);
		end
	end

	always_ff @(posedge clk)
	begin
		wb_dest <= ex_dest;
		wb_data <= ex_result;
	end

endmodule

// File: verilog/risc_core.sv
`timescale 1ns/1ps

module risc_core
(
	input  logic                clk,
	input  logic                reset,
	input  risc_pkg::word_t     instr,
	input  logic                instr_valid,
	output logic                wb_valid,
	output risc_pkg::reg_addr_t wb_dest,
	output risc_pkg::word_t     wb_data,
	output logic                c_flag,
	output logic                z_flag
);
	import risc_pkg::*;

	// Execute stage operands and control
	word_t     op_a;
	word_t     op_b;
	opcode_t   ex_opcode;
	cond_t     ex_cond;
	logic      ex_valid;
	reg_addr_t ex_dest;

	// Functional unit outputs
	word_t sum;
	logic  carry;
	word_t logic_result;

	// Forwarding path from execute
	word_t ex_result;
	logic  ex_write;

	// Decode, operand read and forwarding
	decode_stage u_decode_stage
	(
		.clk         (clk),
		.reset       (reset),
		.instr       (instr),
		.instr_valid (instr_valid),
		.ex_result   (ex_result),
		.ex_write    (ex_write),
		.ex_dest     (ex_dest),
		.wb_valid    (wb_valid),
		.wb_dest     (wb_dest),
		.wb_data     (wb_data),
		.op_a        (op_a),
		.op_b        (op_b),
		.ex_opcode   (ex_opcode),
		.ex_cond     (ex_cond),
		.ex_valid    (ex_valid),
		.ex_dest_out (ex_dest)
	);

	// ADD and ADI
	adder_unit u_adder_unit
	(
		.op_a  (op_a),
		.op_b  (op_b),
		.sum   (sum),
		.carry (carry)
	);

	// NDU and LHI
	logic_unit u_logic_unit
	(
		.opcode (ex_opcode),
		.op_a   (op_a),
		.op_b   (op_b),
		.result (logic_result)
	);

	// Result select, conditions, flags and writeback
	result_stage u_result_stage
	(
		.clk          (clk),
		.reset        (reset),
		.ex_valid     (ex_valid),
		.ex_opcode    (ex_opcode),
		.ex_cond      (ex_cond),
		.ex_dest      (ex_dest),
		.sum          (sum),
		.carry        (carry),
		.logic_result (logic_result),
		.ex_result    (ex_result),
		.ex_write     (ex_write),
		.wb_valid     (wb_valid),
		.wb_dest      (wb_dest),
		.wb_data      (wb_data),
		.c_flag       (c_flag),
		.z_flag       (z_flag)
	);

endmodule

// File: verilog/risc_pkg.sv
package risc_pkg;

	// Datapath and register file sizes
	localparam int WORD_WIDTH     = 16;
	localparam int REG_ADDR_WIDTH = 3;
	localparam int NUM_REGS       = 8;

	// Instruction field widths
	localparam int OPCODE_WIDTH = 4;
	localparam int COND_WIDTH   = 2;
	localparam int IMM6_WIDTH   = 6;
	localparam int IMM9_WIDTH   = 9;

	// Field positions in the 16-bit instruction word
	localparam int OPCODE_LSB = 12;
	localparam int RA_LSB     = 9;
	localparam int RB_LSB     = 6;
	localparam int RC_LSB     = 3;
	localparam int COND_LSB   = 0;

	// LHI places imm9 in the upper bits of the word
	localparam int LHI_SHIFT = 7;

	typedef logic [WORD_WIDTH-1:0]     word_t;
	typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
	typedef logic [COND_WIDTH-1:0]     cond_t;

	// Only the execute subset of the ISA
	typedef enum logic [OPCODE_WIDTH-1:0]
	{
		ADI = 4'd0,
		ADD = 4'd1,
		NDU = 4'd2,
		LHI = 4'd3
	} opcode_t;

	// Condition field of ADD and NDU
	// 10 gives ADC/NDC, 01 gives ADZ/NDZ
	localparam cond_t COND_NONE  = 2'b00;
	localparam cond_t COND_ZERO  = 2'b01;
	localparam cond_t COND_CARRY = 2'b10;

endpackage
